/* hdl/bus_pkg.sv */
// Memory bus types
package bus_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  data_t;

  // Reset vector location, little endian
  localparam addr_t reset_vec_lo = 16'hFFFC;
  localparam addr_t reset_vec_hi = 16'hFFFD;

endpackage

/* hdl/isa_pkg.sv */
// 6502 subset instruction set definitions
package isa_pkg;

  // ----------------------------------------------------------------------
  // Opcodes, standard 6502 encodings
  // ----------------------------------------------------------------------
  localparam logic [7:0] opc_lda_imm = 8'hA9;
  localparam logic [7:0] opc_ldx_imm = 8'hA2;
  localparam logic [7:0] opc_ldy_imm = 8'hA0;
  localparam logic [7:0] opc_lda_abs = 8'hAD;
  localparam logic [7:0] opc_ldx_abs = 8'hAE;
  localparam logic [7:0] opc_ldy_abs = 8'hAC;
  localparam logic [7:0] opc_sta_abs = 8'h8D;
  localparam logic [7:0] opc_stx_abs = 8'h8E;
  localparam logic [7:0] opc_sty_abs = 8'h8C;
  localparam logic [7:0] opc_adc_abs = 8'h6D;
  localparam logic [7:0] opc_and_abs = 8'h2D;
  localparam logic [7:0] opc_ora_abs = 8'h0D;
  localparam logic [7:0] opc_eor_abs = 8'h4D;
  localparam logic [7:0] opc_asl_acc = 8'h0A;
  localparam logic [7:0] opc_lsr_acc = 8'h4A;
  localparam logic [7:0] opc_rol_acc = 8'h2A;
  localparam logic [7:0] opc_ror_acc = 8'h6A;
  localparam logic [7:0] opc_clc_imp = 8'h18;
  localparam logic [7:0] opc_sec_imp = 8'h38;
  localparam logic [7:0] opc_nop_imp = 8'hEA;
  localparam logic [7:0] opc_jmp_abs = 8'h4C;

  // 19 operations need 5 bits
  typedef enum logic [4:0] {
    op_lda, op_ldx, op_ldy, op_sta, op_stx, op_sty,
    op_adc, op_and, op_ora, op_eor,
    op_asl, op_lsr, op_rol, op_ror,
    op_clc, op_sec, op_nop, op_jmp, op_bad
  } op_kind_t;

  // Accumulator forms count as implied
  typedef enum logic [1:0] {
    mode_imp, mode_imm, mode_abs
  } addr_mode_t;

  typedef enum logic [2:0] {
    alu_add, alu_and, alu_or, alu_xor, alu_sr
  } alu_op_t;

endpackage

/* hdl/exec_if.sv */
// Sequencer to execute stage link
interface exec_if;
  import bus_pkg::*;
  import isa_pkg::*;

  // One-cycle strobe, registers update on the edge that ends it
  logic     issue;
  op_kind_t op;
  data_t    operand;
  // Register selected for stores
  data_t    store_data;

  modport seq (
    output issue,
    output op,
    output operand,
    input  store_data
  );

  modport exec (
    input  issue,
    input  op,
    input  operand,
    output store_data
  );

endinterface

/* hdl/opcode_decoder.sv */
// Opcode decode table
module opcode_decoder (
  input  bus_pkg::data_t      opcode,
  output isa_pkg::op_kind_t   op,
  output isa_pkg::addr_mode_t mode
);
  import isa_pkg::*;

  // Operation kind
  always_comb begin
    case (opcode)
      opc_lda_imm: op = op_lda;
      opc_ldx_imm: op = op_ldx;
      opc_ldy_imm: op = op_ldy;
      opc_lda_abs: op = op_lda;
      opc_ldx_abs: op = op_ldx;
      opc_ldy_abs: op = op_ldy;
      opc_sta_abs: op = op_sta;
      opc_stx_abs: op = op_stx;
      opc_sty_abs: op = op_sty;
      opc_adc_abs: op = op_adc;
      opc_and_abs: op = op_and;
      opc_ora_abs: op = op_ora;
      opc_eor_abs: op = op_eor;
      opc_asl_acc: op = op_asl;
      opc_lsr_acc: op = op_lsr;
      opc_rol_acc: op = op_rol;
      opc_ror_acc: op = op_ror;
      opc_clc_imp: op = op_clc;
      opc_sec_imp: op = op_sec;
      opc_nop_imp: op = op_nop;
      opc_jmp_abs: op = op_jmp;
      default:     op = op_bad;
    endcase
  end

  // Addressing mode, implied unless listed
  always_comb begin
    case (opcode)
      opc_lda_imm, opc_ldx_imm, opc_ldy_imm: mode = mode_imm;
      opc_lda_abs, opc_ldx_abs, opc_ldy_abs,
      opc_sta_abs, opc_stx_abs, opc_sty_abs,
      opc_adc_abs, opc_and_abs, opc_ora_abs,
      opc_eor_abs, opc_jmp_abs:              mode = mode_abs;
      default:                               mode = mode_imp;
    endcase
  end

endmodule

/* hdl/alu.sv */
// 8-bit arithmetic and logic unit
module alu (
  input  isa_pkg::alu_op_t op,
  input  bus_pkg::data_t   a,
  input  bus_pkg::data_t   b,
  input  logic             carry_in,
  output bus_pkg::data_t   y,
  output logic             carry_out
);
  import isa_pkg::*;

  always_comb begin
    y         = '0;
    carry_out = 1'b0;
    case (op)
      alu_add: begin
        {carry_out, y} = {1'b0, a} + {1'b0, b} + {8'b0, carry_in};
      end
      alu_and: y = a & b;
      alu_or:  y = a | b;
      alu_xor: y = a ^ b;
      alu_sr: begin
        // Carry in enters at the top
        y         = {carry_in, a[7:1]};
        carry_out = a[0];
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

/* hdl/sequencer.sv */
// Fetch and instruction sequencing
module sequencer (
  input  logic           clk,
  input  logic           resetn,
  input  bus_pkg::data_t rd_data,
  output bus_pkg::addr_t address,
  output bus_pkg::data_t wr_data,
  output logic           wr_enable,
  exec_if.seq            ex
);
  import bus_pkg::*;
  import isa_pkg::*;

  typedef enum logic [7:0] {
    st_reset    = 8'b0000_0001,
    st_vec_lo   = 8'b0000_0010,
    st_vec_hi   = 8'b0000_0100,
    st_fetch    = 8'b0000_1000,
    st_decode   = 8'b0001_0000,
    st_abs_addr = 8'b0010_0000,
    st_abs_data = 8'b0100_0000,
    st_halt     = 8'b1000_0000
  } state_t;

  state_t     state;
  addr_t      pc;
  data_t      ir;
  data_t      operand_lo;
  op_kind_t   op;
  addr_mode_t mode;
  logic       is_store;

  opcode_decoder u_decoder (
    .opcode (ir),
    .op     (op),
    .mode   (mode)
  );

  assign is_store = (op == op_sta) || (op == op_stx) || (op == op_sty);

  // ----------------------------------------------------------------------
  // Execute stage handoff
  // ----------------------------------------------------------------------
  // Short forms issue in decode, absolute loads and ALU ops in the data cycle
  assign ex.issue   = ((state == st_decode) && (mode != mode_abs) && (op != op_bad)) ||
                      ((state == st_abs_data) && !is_store);
  assign ex.op      = op;
  assign ex.operand = rd_data;
  assign wr_data    = ex.store_data;

  // ----------------------------------------------------------------------
  // State, PC and address bus
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= st_reset;
      address   <= reset_vec_lo;
      wr_enable <= 1'b0;
    end else begin
      case (state)
        st_reset: begin
          state <= st_vec_lo;
        end
        st_vec_lo: begin
          pc[7:0] <= rd_data;
          address <= reset_vec_hi;
          state   <= st_vec_hi;
        end
        st_vec_hi: begin
          pc[15:8] <= rd_data;
          address  <= {rd_data, pc[7:0]};
          state    <= st_fetch;
        end
        st_fetch: begin
          ir      <= rd_data;
          address <= pc + 16'd1;
          state   <= st_decode;
        end
        st_decode: begin
          if (op == op_bad) begin
            state <= st_halt;
          end else if (mode == mode_abs) begin
            operand_lo <= rd_data;
            address    <= pc + 16'd2;
            state      <= st_abs_addr;
          end else if (mode == mode_imm) begin
            pc      <= pc + 16'd2;
            address <= pc + 16'd2;
            state   <= st_fetch;
          end else begin
            pc      <= pc + 16'd1;
            address <= pc + 16'd1;
            state   <= st_fetch;
          end
        end
        st_abs_addr: begin
          address <= {rd_data, operand_lo};
          if (op == op_jmp) begin
            pc    <= {rd_data, operand_lo};
            state <= st_fetch;
          end else begin
            // Store strobe covers the data cycle only
            wr_enable <= is_store;
            state     <= st_abs_data;
          end
        end
        st_abs_data: begin
          wr_enable <= 1'b0;
          pc        <= pc + 16'd3;
          address   <= pc + 16'd3;
          state     <= st_fetch;
        end
        default: begin
          state <= st_halt;
        end
      endcase
    end
  end

endmodule

/* hdl/exec_unit.sv */
// Register file and execute stage
module exec_unit (
  input logic  clk,
  input logic  resetn,
  exec_if.exec ex
);
  import bus_pkg::*;
  import isa_pkg::*;

  data_t   acc;
  data_t   x_reg;
  data_t   y_reg;
  logic    carry;

  alu_op_t alu_op;
  data_t   alu_a;
  data_t   alu_b;
  logic    alu_cin;
  data_t   alu_y;
  logic    alu_cout;

  // ----------------------------------------------------------------------
  // ALU operand mapping
  // ----------------------------------------------------------------------
  always_comb begin
    alu_op  = alu_add;
    alu_a   = acc;
    alu_b   = ex.operand;
    alu_cin = carry;
    case (ex.op)
      // Left shifts are A plus A
      op_asl: begin
        alu_b   = acc;
        alu_cin = 1'b0;
      end
      op_rol: alu_b = acc;
      op_lsr: begin
        alu_op  = alu_sr;
        alu_cin = 1'b0;
      end
      op_ror: alu_op = alu_sr;
      op_and: alu_op = alu_and;
      op_ora: alu_op = alu_or;
      op_eor: alu_op = alu_xor;
      default: begin
        alu_op = alu_add;
      end
    endcase
  end

  alu u_alu (
    .op        (alu_op),
    .a         (alu_a),
    .b         (alu_b),
    .carry_in  (alu_cin),
    .y         (alu_y),
    .carry_out (alu_cout)
  );

  // ----------------------------------------------------------------------
  // Register writeback on issue
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc   <= '0;
      x_reg <= '0;
      y_reg <= '0;
      carry <= 1'b0;
    end else if (ex.issue) begin
      case (ex.op)
        op_lda: acc   <= ex.operand;
        op_ldx: x_reg <= ex.operand;
        op_ldy: y_reg <= ex.operand;
        op_adc, op_asl, op_lsr, op_rol, op_ror: begin
          acc   <= alu_y;
          carry <= alu_cout;
        end
        // Carry untouched by logic ops
        op_and, op_ora, op_eor: acc <= alu_y;
        op_clc: carry <= 1'b0;
        op_sec: carry <= 1'b1;
        default: begin
          carry <= carry;
        end
      endcase
    end
  end

  // Store source
  always_comb begin
    case (ex.op)
      op_stx:  ex.store_data = x_reg;
      op_sty:  ex.store_data = y_reg;
      default: ex.store_data = acc;
    endcase
  end

endmodule

/* hdl/cpu_top.sv */
// 6502 subset core top level
module cpu_top (
  input  logic           clk,
  input  logic           resetn,
  input  bus_pkg::data_t rd_data,
  output bus_pkg::addr_t address,
  output bus_pkg::data_t wr_data,
  output logic           wr_enable
);

  exec_if u_exec_if ();

  sequencer u_sequencer (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .ex        (u_exec_if.seq)
  );

  exec_unit u_exec_unit (
    .clk    (clk),
    .resetn (resetn),
    .ex     (u_exec_if.exec)
  );

endmodule

/* test/cpu_asserts.sv */
// Core bus protocol assertions
module cpu_asserts (
  input logic           clk,
  input logic           resetn,
  input bus_pkg::addr_t address,
  input bus_pkg::data_t rd_data,
  input logic           wr_enable
);
  import bus_pkg::*;
  import isa_pkg::*;

  int unsigned violations = 0;
  logic [1:0]  since_reset;
  logic        parked;
  addr_t       addr_d1;
  addr_t       addr_d2;
  addr_t       addr_d3;
  data_t       data_d1;
  data_t       data_d2;
  data_t       data_d3;

  // ----------------------------------------------------------------------
  // Cycles since reset release and JMP-to-self detection
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      since_reset <= 2'd0;
      parked      <= 1'b0;
    end else begin
      if (since_reset != 2'd3) since_reset <= since_reset + 2'd1;
      // JMP fetched at A, operands at A+1 and A+2, then back at A
      if (address == addr_d3 && addr_d2 == addr_d3 + 16'd1 &&
          addr_d1 == addr_d3 + 16'd2 && data_d3 == opc_jmp_abs) begin
        parked <= 1'b1;
      end
    end
    addr_d1 <= address;
    addr_d2 <= addr_d1;
    addr_d3 <= addr_d2;
    data_d1 <= rd_data;
    data_d2 <= data_d1;
    data_d3 <= data_d2;
  end

  vec_lo_first: assert property (@(posedge clk) disable iff (!resetn)
    since_reset == 2'd1 |-> address == 16'hFFFC)
    else begin
      violations++;
      $error("address is not the low reset vector byte after reset");
    end

  vec_hi_second: assert property (@(posedge clk) disable iff (!resetn)
    since_reset == 2'd2 |-> address == 16'hFFFD)
    else begin
      violations++;
      $error("address is not the high reset vector byte after reset");
    end

  single_write: assert property (@(posedge clk) disable iff (!resetn)
    wr_enable |=> !wr_enable)
    else begin
      violations++;
      $error("wr_enable high for two cycles in a row");
    end

  quiet_in_reset: assert property (@(posedge clk)
    (!resetn && $past(!resetn)) |-> !wr_enable)
    else begin
      violations++;
      $error("wr_enable high during reset");
    end

  quiet_when_parked: assert property (@(posedge clk) disable iff (!resetn)
    parked |-> !wr_enable)
    else begin
      violations++;
      $error("write after the final jump to self");
    end

endmodule

bind cpu_top cpu_asserts u_asserts (
  .clk       (clk),
  .resetn    (resetn),
  .address   (address),
  .rd_data   (rd_data),
  .wr_enable (wr_enable)
);

/* test/tb_cpu.sv */
// CPU core testbench
module tb_cpu;
  import bus_pkg::*;
  import isa_pkg::*;

  localparam addr_t zero_byte = 16'h05FF;

  logic        clk = 1'b0;
  logic        resetn;
  data_t       rd_data;
  addr_t       address;
  data_t       wr_data;
  logic        wr_enable;

  logic [7:0]  mem [0:65535];
  logic [31:0] rng = 32'd15448;
  addr_t       build_pc;
  data_t       model_a;
  data_t       model_x;
  data_t       model_y;
  logic        model_c;
  int          n_instr;
  int          errors;
  int          test_errs;
  int          tests_run;
  int          tests_passed;
  bit          build_done = 1'b0;
  addr_t       exp_addr [$];
  data_t       exp_data [$];
  string       exp_name [$];
  bit          exp_last [$];

  cpu_top dut0 (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable)
  );

  assign rd_data = mem[address];

  always #10 clk = ~clk;

  function automatic data_t rand_byte();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng[23:16];
  endfunction

  // ----------------------------------------------------------------------
  // Program assembly with a reference model of the registers
  // ----------------------------------------------------------------------
  task automatic assemble(input data_t opc, input addr_t arg);
    int    len;
    int    sum;
    data_t v;
    logic  c_in;
    case (opc)
      opc_lda_imm, opc_ldx_imm, opc_ldy_imm: len = 2;
      opc_asl_acc, opc_lsr_acc, opc_rol_acc, opc_ror_acc,
      opc_clc_imp, opc_sec_imp, opc_nop_imp: len = 1;
      default: len = 3;
    endcase
    v    = (len == 2) ? arg[7:0] : mem[arg];
    c_in = model_c;
    mem[build_pc] = opc;
    if (len > 1) mem[build_pc + 16'd1] = arg[7:0];
    if (len > 2) mem[build_pc + 16'd2] = arg[15:8];
    build_pc = build_pc + 16'(len);
    n_instr++;
    case (opc)
      opc_lda_imm, opc_lda_abs: model_a = v;
      opc_ldx_imm, opc_ldx_abs: model_x = v;
      opc_ldy_imm, opc_ldy_abs: model_y = v;
      opc_adc_abs: begin
        sum     = int'(model_a) + int'(v) + int'(c_in);
        model_a = sum[7:0];
        model_c = sum[8];
      end
      opc_and_abs: model_a = model_a & v;
      opc_ora_abs: model_a = model_a | v;
      opc_eor_abs: model_a = model_a ^ v;
      opc_asl_acc: begin
        model_c = model_a[7];
        model_a = {model_a[6:0], 1'b0};
      end
      opc_rol_acc: begin
        model_c = model_a[7];
        model_a = {model_a[6:0], c_in};
      end
      opc_lsr_acc: begin
        model_c = model_a[0];
        model_a = {1'b0, model_a[7:1]};
      end
      opc_ror_acc: begin
        model_c = model_a[0];
        model_a = {c_in, model_a[7:1]};
      end
      opc_clc_imp: model_c = 1'b0;
      opc_sec_imp: model_c = 1'b1;
      default: ;
    endcase
  endtask

  task automatic store_and_expect(input data_t opc, input addr_t addr, input string name,
                                  input bit last);
    assemble(opc, addr);
    exp_addr.push_back(addr);
    exp_data.push_back(opc == opc_stx_abs ? model_x : (opc == opc_sty_abs ? model_y : model_a));
    exp_name.push_back(name);
    exp_last.push_back(last);
  endtask

  // A becomes 0 + 0 + carry, then gets stored
  task automatic expose_carry(input addr_t addr, input string name, input bit last);
    assemble(opc_lda_imm, 16'h0000);
    assemble(opc_adc_abs, zero_byte);
    store_and_expect(opc_sta_abs, addr, name, last);
  endtask

  task automatic build_program();
    data_t shift_ops [4];
    data_t r;
    shift_ops = '{opc_asl_acc, opc_lsr_acc, opc_rol_acc, opc_ror_acc};
    for (int i = 0; i < 65536; i++) mem[16'(i)] = 8'(i ^ (i >> 8));
    for (int i = 0; i < 16; i++) mem[16'h0500 + 16'(i)] = rand_byte();
    mem[16'hFFFC]  = 8'h00;
    mem[16'hFFFD]  = 8'h02;
    mem[zero_byte] = 8'h00;
    build_pc = 16'h0200;
    model_c  = 1'b0;
    assemble(opc_lda_imm, {8'h00, rand_byte()});
    assemble(opc_ldx_imm, {8'h00, rand_byte()});
    assemble(opc_ldy_imm, {8'h00, rand_byte()});
    store_and_expect(opc_sta_abs, 16'h0600, "imm_load_store", 1'b0);
    store_and_expect(opc_stx_abs, 16'h0601, "imm_load_store", 1'b0);
    store_and_expect(opc_sty_abs, 16'h0602, "imm_load_store", 1'b1);
    assemble(opc_lda_abs, 16'h0500);
    assemble(opc_ldx_abs, 16'h0501);
    assemble(opc_ldy_abs, 16'h0502);
    store_and_expect(opc_sty_abs, 16'h0610, "abs_load_store", 1'b0);
    store_and_expect(opc_stx_abs, 16'h0611, "abs_load_store", 1'b0);
    store_and_expect(opc_sta_abs, 16'h0612, "abs_load_store", 1'b1);
    // ADC from both carry states
    assemble(opc_clc_imp, 16'h0000);
    assemble(opc_lda_imm, {8'h00, rand_byte()});
    assemble(opc_adc_abs, 16'h0503);
    store_and_expect(opc_sta_abs, 16'h0620, "alu", 1'b0);
    expose_carry(16'h0621, "alu", 1'b0);
    assemble(opc_sec_imp, 16'h0000);
    assemble(opc_lda_imm, {8'h00, rand_byte()});
    assemble(opc_adc_abs, 16'h0504);
    store_and_expect(opc_sta_abs, 16'h0622, "alu", 1'b0);
    expose_carry(16'h0623, "alu", 1'b0);
    assemble(opc_lda_abs, 16'h0505);
    assemble(opc_and_abs, 16'h0506);
    store_and_expect(opc_sta_abs, 16'h0624, "alu", 1'b0);
    assemble(opc_ora_abs, 16'h0507);
    store_and_expect(opc_sta_abs, 16'h0625, "alu", 1'b0);
    assemble(opc_eor_abs, 16'h0508);
    store_and_expect(opc_sta_abs, 16'h0626, "alu", 1'b1);
    foreach (shift_ops[k]) begin
      r = rand_byte();
      assemble(r[0] ? opc_sec_imp : opc_clc_imp, 16'h0000);
      assemble(opc_lda_imm, {8'h00, rand_byte()});
      assemble(shift_ops[k], 16'h0000);
      store_and_expect(opc_sta_abs, 16'h0630 + 16'(2 * k), "shift_carry", 1'b0);
      expose_carry(16'h0631 + 16'(2 * k), "shift_carry", 1'b0);
    end
    // NOP keeps both A and a set carry
    assemble(opc_sec_imp, 16'h0000);
    assemble(opc_lda_imm, {8'h00, rand_byte()});
    assemble(opc_nop_imp, 16'h0000);
    store_and_expect(opc_sta_abs, 16'h0638, "shift_carry", 1'b0);
    expose_carry(16'h0639, "shift_carry", 1'b1);
    // Jump over one store, then park
    assemble(opc_jmp_abs, build_pc + 16'd6);
    assemble(opc_sta_abs, 16'h0640);
    assemble(opc_lda_imm, {8'h00, rand_byte()});
    store_and_expect(opc_sta_abs, 16'h0641, "jump", 1'b1);
    assemble(opc_jmp_abs, build_pc);
  endtask

  // ----------------------------------------------------------------------
  // Checking and reporting
  // ----------------------------------------------------------------------
  task automatic report_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic compare_write(input addr_t got_addr, input data_t got_data);
    addr_t want_addr;
    data_t want_data;
    string name;
    bit    last;
    want_addr = exp_addr.pop_front();
    want_data = exp_data.pop_front();
    name      = exp_name.pop_front();
    last      = exp_last.pop_front();
    if (got_addr !== want_addr || got_data !== want_data) begin
      errors++;
      test_errs++;
      $display("[FAIL] %s: expected %02h at %04h, actual %02h at %04h",
               name, want_data, want_addr, got_data, got_addr);
    end
    if (last) report_test(name);
  endtask

  task automatic verify_address(input addr_t want);
    @(negedge clk);
    if (address !== want) begin
      errors++;
      test_errs++;
      $display("[FAIL] reset_vector: address expected %04h, actual %04h", want, address);
    end
  endtask

  // Memory write and write monitor on the falling edge
  always @(negedge clk) begin
    if (resetn && wr_enable) begin
      mem[address] = wr_data;
      if (exp_addr.size() == 0) begin
        errors++;
        $display("unexpected write of %02h to %04h after the last expected one",
                 wr_data, address);
      end else begin
        compare_write(address, wr_data);
      end
    end
  end

  initial begin
    resetn = 1'b0;
    build_program();
    build_done = 1'b1;
    repeat (10) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    verify_address(16'hFFFC);
    verify_address(16'hFFFD);
    verify_address(16'h0200);
    report_test("reset_vector");
    while (exp_addr.size() != 0) @(posedge clk);
    repeat (40) @(posedge clk);
    $display("tests %0d run, %0d passed, %0d errors, %0d assertion failures",
             tests_run, tests_passed, errors, dut0.u_asserts.violations);
    if (errors == 0 && tests_passed == tests_run && dut0.u_asserts.violations == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (build_done);
    repeat (n_instr * 4 + 100) @(posedge clk);
    $display("timeout: program did not finish within %0d cycles", n_instr * 4 + 100);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* build.f */
hdl/bus_pkg.sv
hdl/isa_pkg.sv
hdl/exec_if.sv
hdl/opcode_decoder.sv
hdl/alu.sv
hdl/sequencer.sv
hdl/exec_unit.sv
hdl/cpu_top.sv
test/cpu_asserts.sv
test/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -qx "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
